/* verilog/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    // ------------------------------
    // Flit geometry
    // ------------------------------
    localparam int LANES  = 4;              // Signed lanes per flit
    localparam int LANE_W = 8;
    localparam int FLIT_W = LANES * LANE_W;

    // ------------------------------
    // Star topology
    // ------------------------------
    localparam int NODE_W     = 3;          // Hub is node 0, leaves 1 to 4
    localparam int NUM_LEAVES = 4;
    localparam int LEAF_IDX_W = 2;          // Index of a leaf, 0 based

    // Link buffering and credit flow
    localparam int LINK_DEPTH = 4;          // Also the initial credit count
    localparam int CREDIT_W   = 3;          // Holds 0 to LINK_DEPTH
    localparam int PTR_W      = 2;          // FIFO pointer width

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [NODE_W-1:0] node_t;

    // Hub output register state
    typedef enum logic {
        OUT_IDLE = 1'b0,
        OUT_HOLD = 1'b1
    } out_state_e;

endpackage

`default_nettype wire

/* verilog/link_buffer.sv */
`default_nettype none

// Receive side of a credit link
module link_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  noc_pkg::flit_t push_data,
    input  logic           pop,
    output noc_pkg::flit_t head,
    output logic           not_empty,
    output logic           credit
);
    import noc_pkg::*;

    flit_t               mem [LINK_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;     // Entries held

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at LINK_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Each freed slot goes back to the sender right away
    assign credit = pop;

    // ------------------------------
    // Protocol checks
    // ------------------------------
    // Sender pushed without a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CREDIT_W'(LINK_DEPTH)) || pop);

    // Reader popped a slot that was never filled
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

endmodule

`default_nettype wire

/* verilog/hub_ctrl.sv */
`default_nettype none

module hub_ctrl (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  noc_pkg::flit_t                           in_data,
    input  noc_pkg::node_t                           in_dest,
    output logic [noc_pkg::NUM_LEAVES-1:0]           fwd_send,
    output noc_pkg::flit_t                           fwd_data,
    input  logic [noc_pkg::NUM_LEAVES-1:0]           fwd_credit,
    input  logic [noc_pkg::NUM_LEAVES-1:0]           ret_not_empty,
    input  noc_pkg::flit_t [noc_pkg::NUM_LEAVES-1:0] ret_head,
    output logic [noc_pkg::NUM_LEAVES-1:0]           ret_pop,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output noc_pkg::flit_t                           out_data,
    output noc_pkg::node_t                           out_src
);
    import noc_pkg::*;

    logic [CREDIT_W-1:0]   credit_cnt [NUM_LEAVES];
    logic                  dest_ok;
    logic [LEAF_IDX_W-1:0] dest_idx;
    logic                  has_credit;

    out_state_e            state;
    logic                  take;        // Output register may be reloaded
    logic [LEAF_IDX_W-1:0] rr_last;     // Last leaf served
    logic [LEAF_IDX_W-1:0] grant_idx;
    logic                  grant_any;

    // ------------------------------
    // Destination decode
    // ------------------------------
    always_comb begin
        dest_ok    = (in_dest >= node_t'(1)) && (in_dest <= node_t'(NUM_LEAVES));
        dest_idx   = LEAF_IDX_W'(in_dest - node_t'(1));
        has_credit = (credit_cnt[dest_idx] != '0);

        // Bad destinations are swallowed and never stalled
        in_ready = !dest_ok || has_credit;

        fwd_send = '0;
        if (in_valid && dest_ok && has_credit) begin
            fwd_send[dest_idx] = 1'b1;
        end
    end

    assign fwd_data = in_data;      // Shared bus whose strobe selects the leaf

    // Send spends a credit and a pop in the leaf earns one back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < NUM_LEAVES; n++) begin
                credit_cnt[n] <= CREDIT_W'(LINK_DEPTH);
            end
        end else begin
            for (int n = 0; n < NUM_LEAVES; n++) begin
                case ({fwd_send[n], fwd_credit[n]})
                    2'b10:   credit_cnt[n] <= credit_cnt[n] - 1'b1;
                    2'b01:   credit_cnt[n] <= credit_cnt[n] + 1'b1;
                    default: credit_cnt[n] <= credit_cnt[n];
                endcase
            end
        end
    end

    // ------------------------------
    // Return arbitration
    // ------------------------------
    assign take = (state == OUT_IDLE) || out_ready;

    // Search starts one past the last winner
    always_comb begin
        logic [LEAF_IDX_W-1:0] cand;
        grant_idx = '0;
        grant_any = 1'b0;
        for (int i = 0; i < NUM_LEAVES; i++) begin
            cand = LEAF_IDX_W'(rr_last + i + 1);
            if (!grant_any && ret_not_empty[cand]) begin
                grant_idx = cand;
                grant_any = 1'b1;
            end
        end

        ret_pop = '0;
        if (take && grant_any) begin
            ret_pop[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= OUT_IDLE;
            rr_last <= LEAF_IDX_W'(NUM_LEAVES - 1);   // Leaf 1 wins first
        end else if (take) begin
            if (grant_any) begin
                state   <= OUT_HOLD;
                rr_last <= grant_idx;
            end else begin
                state <= OUT_IDLE;
            end
        end
    end

    // Output payload is loaded on the pop edge
    always_ff @(posedge clk) begin
        if (take && grant_any) begin
            out_data <= ret_head[grant_idx];
            out_src  <= node_t'(grant_idx + 1);
        end
    end

    assign out_valid = (state == OUT_HOLD);

    // ------------------------------
    // Checks
    // ------------------------------
    for (genvar n = 0; n < NUM_LEAVES; n++) begin : g_credit_chk
        // A leaf returned more credits than it was given
        a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
            credit_cnt[n] <= CREDIT_W'(LINK_DEPTH));
    end

endmodule

`default_nettype wire

/* verilog/relu_pe.sv */
`default_nettype none

// Leaf node: buffer, lane-wise ReLU, credit-limited return
module relu_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fwd_send,
    input  noc_pkg::flit_t fwd_data,
    output logic           fwd_credit,
    output logic           ret_send,
    output noc_pkg::flit_t ret_data,
    input  logic           ret_credit
);
    import noc_pkg::*;

    flit_t               in_head;
    logic                in_not_empty;
    logic                in_pop;
    logic [CREDIT_W-1:0] ret_cnt;       // Free slots in the hub's return buffer

    // Clamp negative lanes to zero
    function automatic flit_t relu(input flit_t x);
        flit_t y;
        y = x;
        for (int l = 0; l < LANES; l++) begin
            if (x[l*LANE_W + LANE_W - 1]) begin
                y[l*LANE_W +: LANE_W] = '0;
            end
        end
        return y;
    endfunction

    // ------------------------------
    // Input link
    // ------------------------------
    link_buffer u_in_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fwd_send),
        .push_data (fwd_data),
        .pop       (in_pop),
        .head      (in_head),
        .not_empty (in_not_empty),
        .credit    (fwd_credit)
    );

    // Only pop when the result has somewhere to go
    assign in_pop = in_not_empty && (ret_cnt != '0);

    // ------------------------------
    // Return sender
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_send <= 1'b0;
            ret_cnt  <= CREDIT_W'(LINK_DEPTH);
        end else begin
            ret_send <= in_pop;
            case ({in_pop, ret_credit})
                2'b10:   ret_cnt <= ret_cnt - 1'b1;   // Slot reserved at pop
                2'b01:   ret_cnt <= ret_cnt + 1'b1;
                default: ret_cnt <= ret_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_pop) begin
            ret_data <= relu(in_head);
        end
    end

    // Hub never frees more slots than it has
    a_ret_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        ret_cnt <= CREDIT_W'(LINK_DEPTH));

endmodule

`default_nettype wire

/* verilog/noc_star.sv */
`default_nettype none

// Five-node star: hub router plus four ReLU leaves
module noc_star (
    input  logic           clk,
    input  logic           rst_n,

    // Master stream in
    input  logic           in_valid,
    output logic           in_ready,
    input  noc_pkg::flit_t in_data,
    input  noc_pkg::node_t in_dest,

    // Master stream out
    output logic           out_valid,
    input  logic           out_ready,
    output noc_pkg::flit_t out_data,
    output noc_pkg::node_t out_src
);
    import noc_pkg::*;

    // Hub to leaves
    logic [NUM_LEAVES-1:0]  fwd_send;
    flit_t                  fwd_data;
    logic [NUM_LEAVES-1:0]  fwd_credit;

    // Leaves to return buffers
    logic [NUM_LEAVES-1:0]  ret_send;
    flit_t [NUM_LEAVES-1:0] ret_data;
    logic [NUM_LEAVES-1:0]  ret_credit;

    // Return buffers to hub
    logic [NUM_LEAVES-1:0]  ret_pop;
    logic [NUM_LEAVES-1:0]  ret_not_empty;
    flit_t [NUM_LEAVES-1:0] ret_head;

    // ------------------------------
    // Hub router, node 0
    // ------------------------------
    hub_ctrl u_hub (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_dest       (in_dest),
        .fwd_send      (fwd_send),
        .fwd_data      (fwd_data),
        .fwd_credit    (fwd_credit),
        .ret_not_empty (ret_not_empty),
        .ret_head      (ret_head),
        .ret_pop       (ret_pop),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_src       (out_src)
    );

    // ------------------------------
    // Leaves, nodes 1 to 4
    // ------------------------------
    for (genvar n = 0; n < NUM_LEAVES; n++) begin : g_leaf
        relu_pe u_pe (
            .clk        (clk),
            .rst_n      (rst_n),
            .fwd_send   (fwd_send[n]),
            .fwd_data   (fwd_data),
            .fwd_credit (fwd_credit[n]),
            .ret_send   (ret_send[n]),
            .ret_data   (ret_data[n]),
            .ret_credit (ret_credit[n])
        );

        // Hub side of the return link
        link_buffer u_ret_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (ret_send[n]),
            .push_data (ret_data[n]),
            .pop       (ret_pop[n]),
            .head      (ret_head[n]),
            .not_empty (ret_not_empty[n]),
            .credit    (ret_credit[n])
        );
    end

endmodule

`default_nettype wire

/* tests/tb_noc_star.sv */
`default_nettype none

module tb_noc_star;
    timeunit 1ns;
    timeprecision 1ps;

    import noc_pkg::*;

    localparam int WAIT_LIMIT  = 300;   // Cycles per wait loop
    localparam int NUM_FLITS   = 300;
    localparam int HOLD_CYCLES = 100;

    localparam int READY_LOW    = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_HIGH   = 2;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    logic  in_ready;
    flit_t in_data;
    node_t in_dest;
    logic  out_valid;
    logic  out_ready;
    flit_t out_data;
    node_t out_src;

    // Scoreboard state
    flit_t                 pending [NUM_LEAVES][$];   // Expected results per leaf
    flit_t                 head_data [NUM_LEAVES];
    logic                  head_valid [NUM_LEAVES];
    logic [LEAF_IDX_W-1:0] src_idx;
    int                    sent_count;
    int                    dropped_count;
    int                    out_count;

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    int          ready_mode;
    logic        stall_seen;
    int          cycles;

    noc_star uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_src   (out_src)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Negative lanes become zero and the rest pass through
    function automatic flit_t relu_model(input flit_t x);
        flit_t                    y;
        logic signed [LANE_W-1:0] lane;
        y = '0;
        for (int l = 0; l < LANES; l++) begin
            lane = x[l*LANE_W +: LANE_W];
            if (lane > 0) begin
                y[l*LANE_W +: LANE_W] = lane;
            end
        end
        return y;
    endfunction

    function automatic logic queues_empty();
        for (int n = 0; n < NUM_LEAVES; n++) begin
            if (pending[n].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic fail_words(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic fail_value(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
        $display("ERR %s expected %h actual %h", test, exp, act);
        stop_run();
    endtask

    // Changes take effect from the next rising edge
    task automatic set_ready_mode(input int mode);
        @(negedge clk);
        ready_mode = mode;
        @(posedge clk);
        #2;
    endtask

    // Called 2 ns after an edge and returns 2 ns after the transfer edge
    task automatic send_flit(input flit_t data, input node_t dest);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = data;
        in_dest  = dest;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_words($sformatf("in_ready stayed low for node %0d", dest));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // Runs until as many results came out as flits went to leaves
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count != sent_count || out_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_words("results still pending after the drain timeout");
            end
            @(posedge clk);
            #2;
        end
    endtask

    // ------------------------------
    // Output ready driver
    // ------------------------------
    always @(posedge clk) begin
        #2;
        ready_state = xorshift32(ready_state);
        case (ready_mode)
            READY_LOW:    out_ready = 1'b0;
            READY_RANDOM: out_ready = (ready_state[1:0] != 2'b00);   // About 3 in 4
            default:      out_ready = 1'b1;
        endcase
    end

    // ------------------------------
    // Scoreboard updated at the falling edge
    // ------------------------------
    assign src_idx = LEAF_IDX_W'(out_src - node_t'(1));

    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                out_count++;
                if (out_src >= 1 && out_src <= NUM_LEAVES && pending[src_idx].size() > 0) begin
                    void'(pending[src_idx].pop_front());
                end
            end
            if (in_valid && in_ready) begin
                if (in_dest >= 1 && in_dest <= NUM_LEAVES) begin
                    pending[int'(in_dest) - 1].push_back(relu_model(in_data));
                    sent_count++;
                end else begin
                    dropped_count++;   // Hub swallows it
                end
            end
        end
        for (int n = 0; n < NUM_LEAVES; n++) begin
            head_valid[n] = (pending[n].size() > 0);
            head_data[n]  = head_valid[n] ? pending[n][0] : '0;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_reset_quiet: assert property (@(negedge clk) !rst_n || $rose(rst_n) |-> !out_valid)
        else fail_value("reset out_valid", 32'd0, 32'($sampled(out_valid)));

    a_src_range: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid |-> out_src >= 1 && out_src <= NUM_LEAVES)
        else fail_words($sformatf("out_src %0d names no leaf", $sampled(out_src)));

    // Catches results from dropped flits and from the wrong leaf
    a_result_expected: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> head_valid[src_idx])
        else fail_words($sformatf("result from node %0d with nothing pending",
                                  $sampled(out_src)));

    for (genvar l = 0; l < LANES; l++) begin : g_lane_chk
        a_lane: assert property (@(negedge clk) disable iff (!rst_n)
            out_valid && out_ready && head_valid[src_idx]
            |-> out_data[l*LANE_W +: LANE_W] == head_data[src_idx][l*LANE_W +: LANE_W])
            else fail_value($sformatf("relu lane %0d node %0d", l, $sampled(out_src)),
                            32'($sampled(head_data[src_idx][l*LANE_W +: LANE_W])),
                            32'($sampled(out_data[l*LANE_W +: LANE_W])));
    end

    a_out_hold: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_src))
        else fail_words("output changed while out_ready was low");

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        node_t       dest;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_dest       = '0;
        out_ready     = 1'b0;
        ready_mode    = READY_LOW;
        sent_count    = 0;
        dropped_count = 0;
        out_count     = 0;
        stim_state    = 32'd68;
        ready_state   = xorshift32(32'd68) ^ 32'h9e37_79b9;

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // Mixed traffic with about 1 in 8 flits to a bad node
        set_ready_mode(READY_RANDOM);
        for (int i = 0; i < NUM_FLITS; i++) begin
            stim_state = xorshift32(stim_state);
            r          = stim_state;
            if (r[2:0] == 3'd0) begin
                dest = (r[4:3] == 2'd0) ? node_t'(0) : node_t'(r[4:3]) + node_t'(4);
            end else begin
                dest = node_t'(r[4:3]) + node_t'(1);
            end
            stim_state = xorshift32(stim_state);
            send_flit(stim_state, dest);
            if (r[7:5] == 3'd0) begin
                @(posedge clk);   // Idle gap
                #2;
            end
        end
        wait_drain();
        assert (queues_empty())
            else fail_words("scoreboard queues not empty after drain");

        // Back-pressure on node 2
        set_ready_mode(READY_LOW);
        stall_seen = 1'b0;
        cycles     = 0;
        in_valid   = 1'b1;
        in_dest    = node_t'(2);
        stim_state = xorshift32(stim_state);
        in_data    = stim_state;
        while (!stall_seen && cycles < HOLD_CYCLES) begin
            @(negedge clk);
            if (!in_ready) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #2;
            cycles++;
            if (!stall_seen) begin
                stim_state = xorshift32(stim_state);
                in_data    = stim_state;
            end
        end
        in_valid = 1'b0;
        assert (stall_seen)
            else fail_words("in_ready never dropped while out_ready was held low");
        while (cycles < HOLD_CYCLES) begin
            @(posedge clk);
            #2;
            cycles++;
        end

        set_ready_mode(READY_HIGH);
        wait_drain();
        assert (queues_empty())
            else fail_words("results left in the scoreboard after back-pressure release");

        $display("Flits sent %0d, dropped %0d, results %0d",
                 sent_count, dropped_count, out_count);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/noc_pkg.sv
verilog/link_buffer.sv
verilog/hub_ctrl.sv
verilog/relu_pe.sv
verilog/noc_star.sv
tests/tb_noc_star.sv

/* Bender.yml */
package:
  name: noc_star

sources:
  - files:
      - verilog/noc_pkg.sv
      - verilog/link_buffer.sv
      - verilog/hub_ctrl.sv
      - verilog/relu_pe.sv
      - verilog/noc_star.sv
  - target: test
    files:
      - tests/tb_noc_star.sv
